/* hw/loopback_params.svh */
// Frame geometry and pixel packing of the loopback checker
// Receiver error clean value, clear period and LED flash width

`ifndef LOOPBACK_PARAMS_SVH
`define LOOPBACK_PARAMS_SVH

// Small frame so that one frame simulates quickly
`define FRAME_WIDTH       16
`define FRAME_HEIGHT      4
`define FRAME_PIXELS      (`FRAME_WIDTH * `FRAME_HEIGHT)

// RGB565, four pixels per received 64-bit word
`define PIXELS_PER_WORD   4
`define PIXEL_BITS        16

// Receiver status value when no error is pending
`define RX_ERR_CLEAN      18'h200
`define ERR_CHECK_PERIOD  16
`define FLASH_BITS        25

`endif

/* hw/video_pkg.sv */
// Video types: RGB565 fields, pixel word union,
// frame position and pattern index

package video_pkg;

`include "loopback_params.svh"

   // RGB565 layout, red in the top bits
   typedef struct packed {
      logic [4:0] red;
      logic [5:0] green;
      logic [4:0] blue;
   } rgb565_t;

   // One pixel word, seen raw or as colour fields
   typedef union packed {
      logic [`PIXEL_BITS-1:0] raw;
      rgb565_t                rgb;
   } pixel_u;

   // Column and line inside the active frame
   typedef struct packed {
      logic [7:0] x;
      logic [7:0] y;
   } frame_pos_t;

   typedef logic [1:0] pattern_t;

endpackage

/* hw/mipi_rx_pkg.sv */
// Receiver interface types: packed pixel word
// and receiver error status

package mipi_rx_pkg;

`include "loopback_params.svh"

   // Four pixels per word
   // Element 3 sits in the top bits and is sent first
   typedef video_pkg::pixel_u [`PIXELS_PER_WORD-1:0] rx_word_t;

   // Receiver error status word
   typedef logic [17:0] rx_error_t;

endpackage

/* hw/pattern_select.sv */
// Pattern select: button synchronizer, rising edge
// detect and 2-bit pattern index

`timescale 1ns/1ps

module pattern_select (
   input  logic                rx_vga_clk,
   input  logic                rst_n,
   input  logic                btn_i,
   output video_pkg::pattern_t pattern_o
);

   // Two-flop synchronizer plus one delay stage for the edge
   logic [1:0] btn_sync;
   logic       btn_d;
   logic       btn_rise;

   assign btn_rise = btn_sync[1] & ~btn_d;

   always_ff @(posedge rx_vga_clk) begin
      if (!rst_n) begin
         btn_sync  <= 2'b00;
         btn_d     <= 1'b0;
         pattern_o <= '0;
      end else begin
         btn_sync <= {btn_sync[0], btn_i};
         btn_d    <= btn_sync[1];
         // Index wraps naturally after pattern 3
         if (btn_rise) begin
            pattern_o <= pattern_o + 1'b1;
         end
      end
   end

endmodule

/* hw/golden_pattern.sv */
// Golden pixel generator
// Decodes frame position and pattern index into the expected pixel

`timescale 1ns/1ps

`include "loopback_params.svh"

module golden_pattern (
   input  video_pkg::frame_pos_t pos_i,
   input  video_pkg::pattern_t   pattern_i,
   output video_pkg::pixel_u     golden_o
);

   // ****************************************
   // Pattern decode, purely combinational
   // ****************************************

   always_comb begin
      golden_o.raw = '0;
      case (pattern_i)
         // Position ramp, line in the upper byte
         2'd0: begin
            golden_o.raw = {pos_i.y, pos_i.x};
         end
         // Solid red
         2'd1: begin
            golden_o.rgb.red   = 5'h1f;
            golden_o.rgb.green = 6'h00;
            golden_o.rgb.blue  = 5'h00;
         end
         // Checkerboard of single pixels
         2'd2: begin
            golden_o.raw = {`PIXEL_BITS{pos_i.x[0] ^ pos_i.y[0]}};
         end
         // Colour bars: red ramps with x, blue the opposite way
         default: begin
            golden_o.rgb.red   = pos_i.x[4:0];
            golden_o.rgb.green = pos_i.y[5:0];
            golden_o.rgb.blue  = ~pos_i.x[4:0];
         end
      endcase
   end

endmodule

/* hw/pixel_depacker.sv */
// Pixel depacker
// Latches a 64-bit received word and emits its four pixels,
// one per cycle, most significant pixel first

`timescale 1ns/1ps

`include "loopback_params.svh"

module pixel_depacker (
   input  logic                  rx_vga_clk,
   input  logic                  rst_n,
   input  logic                  word_valid_i,
   input  mipi_rx_pkg::rx_word_t word_i,
   output logic                  pix_valid_o,
   output video_pkg::pixel_u     pix_o
);

   import mipi_rx_pkg::*;

   localparam int SLOT_BITS = $clog2(`PIXELS_PER_WORD);

   // Latched word, slot index and busy flag
   rx_word_t             word_q;
   logic [SLOT_BITS-1:0] slot;
   logic                 busy;

   always_ff @(posedge rx_vga_clk) begin
      if (word_valid_i) begin
         word_q <= word_i;
      end
   end

   // Slot counts down from the top pixel
   always_ff @(posedge rx_vga_clk) begin
      if (!rst_n) begin
         busy <= 1'b0;
         slot <= '0;
      end else if (word_valid_i) begin
         busy <= 1'b1;
         slot <= SLOT_BITS'(`PIXELS_PER_WORD - 1);
      end else if (busy) begin
         slot <= slot - 1'b1;
         // Last pixel of the word goes out this cycle
         if (slot == '0) begin
            busy <= 1'b0;
         end
      end
   end

   // Idle bus reads as zero
   assign pix_valid_o = busy;
   assign pix_o       = busy ? word_q[slot] : '0;

endmodule

/* hw/error_monitor.sv */
// Receiver error monitor
// Registers the error status, flags the clean state and pulses
// an error clear once per check period while the status is dirty

`timescale 1ns/1ps

`include "loopback_params.svh"

module error_monitor (
   input  logic                   rx_vga_clk,
   input  logic                   rst_n,
   input  mipi_rx_pkg::rx_error_t rx_error_i,
   output logic                   rx_clear_o,
   output logic                   err_clean_o
);

   import mipi_rx_pkg::*;

   localparam int CNT_BITS = $clog2(`ERR_CHECK_PERIOD);

   rx_error_t           err_q;
   logic [CNT_BITS-1:0] period_cnt;

   // Receiver status sampled every cycle
   always_ff @(posedge rx_vga_clk) begin
      err_q <= rx_error_i;
   end

   assign err_clean_o = (err_q == `RX_ERR_CLEAN);

   // Clear is held during reset so the receiver starts clean
   always_ff @(posedge rx_vga_clk) begin
      if (!rst_n) begin
         period_cnt <= '0;
         rx_clear_o <= 1'b1;
      end else begin
         period_cnt <= period_cnt + 1'b1;
         rx_clear_o <= (period_cnt == CNT_BITS'(`ERR_CHECK_PERIOD - 1)) && !err_clean_o;
      end
   end

endmodule

/* hw/frame_checker.sv */
// Frame checker: frame position, consecutive match count,
// last frame result and pass LED flasher

`timescale 1ns/1ps

`include "loopback_params.svh"

module frame_checker (
   input  logic                  rx_vga_clk,
   input  logic                  rst_n,
   input  logic                  pix_valid_i,
   input  video_pkg::pixel_u     pix_i,
   input  video_pkg::pixel_u     golden_i,
   input  logic                  vsync_i,
   input  logic                  err_clean_i,
   output video_pkg::frame_pos_t pos_o,
   output logic                  frame_pass_o,
   output logic                  led_a_o,
   output logic                  led_b_o
);

   localparam int CNT_BITS = $clog2(`FRAME_PIXELS + 1);

   logic                  vsync_d;
   logic                  frame_start;
   logic                  pix_match;
   logic [CNT_BITS-1:0]   match_cnt;
   logic [CNT_BITS-1:0]   last_cnt;
   logic [`FLASH_BITS-1:0] flash_cnt;

   assign frame_start = vsync_i & ~vsync_d;
   assign pix_match   = (pix_i.raw == golden_i.raw);

   // ****************************************
   // Position and match counting
   // ****************************************

   always_ff @(posedge rx_vga_clk) begin
      if (!rst_n) begin
         vsync_d   <= 1'b0;
         pos_o     <= '0;
         match_cnt <= '0;
         last_cnt  <= '0;
      end else begin
         vsync_d <= vsync_i;
         // Frame start wins over a pixel in the same cycle
         if (frame_start) begin
            pos_o     <= '0;
            last_cnt  <= match_cnt;
            match_cnt <= '0;
         end else if (pix_valid_i) begin
            // Any mismatch restarts the run
            match_cnt <= pix_match ? match_cnt + 1'b1 : '0;
            if (pos_o.x == 8'(`FRAME_WIDTH - 1)) begin
               pos_o.x <= '0;
               pos_o.y <= (pos_o.y == 8'(`FRAME_HEIGHT - 1)) ? 8'd0 : pos_o.y + 8'd1;
            end else begin
               pos_o.x <= pos_o.x + 8'd1;
            end
         end
      end
   end

   // ****************************************
   // Frame result and LED flasher
   // ****************************************

   always_ff @(posedge rx_vga_clk) begin
      if (!rst_n) begin
         frame_pass_o <= 1'b0;
         flash_cnt    <= '0;
      end else begin
         frame_pass_o <= (last_cnt == CNT_BITS'(`FRAME_PIXELS)) && err_clean_i;
         // Counter only runs while passing
         flash_cnt    <= frame_pass_o ? flash_cnt + 1'b1 : '0;
      end
   end

   // Both LEDs on while failing, alternate while passing
   assign led_a_o = ~frame_pass_o | flash_cnt[`FLASH_BITS-1];
   assign led_b_o = ~frame_pass_o | ~flash_cnt[`FLASH_BITS-1];

endmodule

/* hw/loopback_checker_top.sv */
// Receive side checker of the MIPI video loopback
// Depacker, golden generator, pattern select, error monitor
// and frame checker, all on rx_vga_clk

`timescale 1ns/1ps

module loopback_checker_top (
   input  logic                   rx_vga_clk,
   input  logic                   rst_n,
   input  logic                   rx_valid_i,
   input  mipi_rx_pkg::rx_word_t  rx_data_i,
   input  logic                   rx_vsync_i,
   input  mipi_rx_pkg::rx_error_t rx_error_i,
   input  logic                   pattern_btn_i,
   output logic                   rx_clear_o,
   output logic                   frame_pass_o,
   output logic                   led_a_o,
   output logic                   led_b_o
);

   import video_pkg::*;

   logic       pix_valid;
   pixel_u     pix;
   pixel_u     golden;
   frame_pos_t pos;
   pattern_t   pattern;
   logic       err_clean;

   // Pixel stream from received words
   pixel_depacker u_depacker (
      .rx_vga_clk  (rx_vga_clk),
      .rst_n       (rst_n),
      .word_valid_i(rx_valid_i),
      .word_i      (rx_data_i),
      .pix_valid_o (pix_valid),
      .pix_o       (pix)
   );

   // Pattern configuration and expected pixel
   pattern_select u_pattern_select (
      .rx_vga_clk(rx_vga_clk),
      .rst_n     (rst_n),
      .btn_i     (pattern_btn_i),
      .pattern_o (pattern)
   );

   golden_pattern u_golden (
      .pos_i    (pos),
      .pattern_i(pattern),
      .golden_o (golden)
   );

   error_monitor u_error_monitor (
      .rx_vga_clk (rx_vga_clk),
      .rst_n      (rst_n),
      .rx_error_i (rx_error_i),
      .rx_clear_o (rx_clear_o),
      .err_clean_o(err_clean)
   );

   frame_checker u_frame_checker (
      .rx_vga_clk  (rx_vga_clk),
      .rst_n       (rst_n),
      .pix_valid_i (pix_valid),
      .pix_i       (pix),
      .golden_i    (golden),
      .vsync_i     (rx_vsync_i),
      .err_clean_i (err_clean),
      .pos_o       (pos),
      .frame_pass_o(frame_pass_o),
      .led_a_o     (led_a_o),
      .led_b_o     (led_b_o)
   );

endmodule

/* tb/tb_clock_gen.sv */
// Testbench clock and reset source
// Free running clock, reset held low for a fixed number of cycles

`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int CLK_PERIOD   = 8,
   parameter int RESET_CYCLES = 8
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(CLK_PERIOD / 2) clk_o = ~clk_o;
   end

   // Release on a falling edge, away from the sampling edge
   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

endmodule

/* tb/loopback_checker_asserts.sv */
// Concurrent assertions on the loopback checker top level
// Word spacing, pixel burst length, pass flag and LED state

`timescale 1ns/1ps

`include "loopback_params.svh"

module loopback_checker_asserts (
   input logic                   clk_i,
   input logic                   rst_n_i,
   input logic                   word_valid_i,
   input logic                   pix_valid_i,
   input mipi_rx_pkg::rx_error_t rx_error_i,
   input logic                   frame_pass_i,
   input logic                   led_a_i,
   input logic                   led_b_i
);

   // Number of property failures
   int unsigned fail_cnt = 0;

   // Saturating count of cycles since the last word strobe
   logic [2:0] word_gap;
   // Saturating count of consecutive cycles with a pixel strobe
   logic [2:0] pix_run;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         word_gap <= 3'd7;
         pix_run  <= 3'd0;
      end else begin
         if (word_valid_i) begin
            word_gap <= 3'd1;
         end else if (word_gap != 3'd7) begin
            word_gap <= word_gap + 3'd1;
         end
         if (!pix_valid_i) begin
            pix_run <= 3'd0;
         end else if (pix_run != 3'd7) begin
            pix_run <= pix_run + 3'd1;
         end
      end
   end

   // ****************************************
   // Protocol and output properties
   // ****************************************

   // Next word only once the depacker is idle again
   word_spacing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      word_valid_i |-> (word_gap >= 3'd4))
   else begin
      $error("word strobe arrived while the depacker was busy");
      fail_cnt++;
   end

   pixel_burst: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pix_valid_i |-> (pix_run < 3'd4))
   else begin
      $error("pixel strobe high for more than four cycles");
      fail_cnt++;
   end

   // Status register and pass register put two cycles between them
   pass_needs_clean: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      frame_pass_i |-> ($past(rx_error_i, 2) == `RX_ERR_CLEAN))
   else begin
      $error("frame pass high while the error status was dirty");
      fail_cnt++;
   end

   leds_when_failing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !frame_pass_i |-> (led_a_i && led_b_i))
   else begin
      $error("LEDs not both on while the frame check fails");
      fail_cnt++;
   end

endmodule

/* tb/loopback_checker_tb.sv */
// Testbench of the loopback checker
// Stimulus table, frame builder with golden model, checks and watchdog

`timescale 1ns/1ps

`include "loopback_params.svh"

module loopback_checker_tb;

   import video_pkg::*;
   import mipi_rx_pkg::*;

   localparam int CLK_PERIOD      = 8;
   localparam int RESET_CYCLES    = 8;
   localparam int NUM_ROWS        = 10;
   localparam int WORDS_PER_FRAME = `FRAME_PIXELS / `PIXELS_PER_WORD;
   localparam int WORD_GAP        = 6;
   localparam int FRAME_MARGIN    = 80;
   // Two frames per row plus presses and the clear window in the margin
   localparam int WATCHDOG_NS     = (RESET_CYCLES + NUM_ROWS * 2 *
                                     (WORDS_PER_FRAME * WORD_GAP + FRAME_MARGIN)) * CLK_PERIOD;

   localparam rx_error_t CLEAN = `RX_ERR_CLEAN;
   localparam rx_error_t DIRTY = 18'h201;

   // One test: presses before it, status, corruption, expected result
   typedef struct packed {
      logic [1:0] presses;
      rx_error_t  status;
      logic       corrupt;
      logic       wrong_pat;
      logic       exp_pass;
   } row_t;

   localparam row_t TEST_ROWS [NUM_ROWS] = '{
      '{2'd0, CLEAN, 1'b0, 1'b0, 1'b1},   // pattern 0
      '{2'd1, CLEAN, 1'b0, 1'b0, 1'b1},   // pattern 1
      '{2'd1, CLEAN, 1'b0, 1'b0, 1'b1},   // pattern 2
      '{2'd1, CLEAN, 1'b0, 1'b0, 1'b1},   // pattern 3
      '{2'd0, CLEAN, 1'b1, 1'b0, 1'b0},   // one bad pixel
      '{2'd0, CLEAN, 1'b0, 1'b0, 1'b1},
      '{2'd0, DIRTY, 1'b0, 1'b0, 1'b0},   // receiver error pending
      '{2'd1, CLEAN, 1'b0, 1'b0, 1'b1},   // back to pattern 0
      '{2'd0, CLEAN, 1'b0, 1'b1, 1'b0},   // source sends the next pattern
      '{2'd0, CLEAN, 1'b0, 1'b0, 1'b1}
   };

   logic        rx_vga_clk;
   logic        rst_n;
   logic        rx_valid;
   rx_word_t    rx_data;
   logic        rx_vsync;
   rx_error_t   rx_error;
   logic        pattern_btn;
   logic        rx_clear;
   logic        frame_pass;
   logic        led_a;
   logic        led_b;

   pattern_t    model_pat;
   logic [31:0] rng_state;
   int          checks;
   int          errors;

   tb_clock_gen #(
      .CLK_PERIOD  (CLK_PERIOD),
      .RESET_CYCLES(RESET_CYCLES)
   ) u_clock_gen (
      .clk_o  (rx_vga_clk),
      .rst_n_o(rst_n)
   );

   loopback_checker_top dut (
      .rx_vga_clk   (rx_vga_clk),
      .rst_n        (rst_n),
      .rx_valid_i   (rx_valid),
      .rx_data_i    (rx_data),
      .rx_vsync_i   (rx_vsync),
      .rx_error_i   (rx_error),
      .pattern_btn_i(pattern_btn),
      .rx_clear_o   (rx_clear),
      .frame_pass_o (frame_pass),
      .led_a_o      (led_a),
      .led_b_o      (led_b)
   );

   bind loopback_checker_top loopback_checker_asserts u_asserts (
      .clk_i       (rx_vga_clk),
      .rst_n_i     (rst_n),
      .word_valid_i(rx_valid_i),
      .pix_valid_i (pix_valid),
      .rx_error_i  (rx_error_i),
      .frame_pass_i(frame_pass_o),
      .led_a_i     (led_a_o),
      .led_b_i     (led_b_o)
   );

   // ****************************************
   // Golden model and frame builder
   // ****************************************

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Raw RGB565 word: red in bits 15:11, green 10:5, blue 4:0
   function automatic logic [15:0] expected_pixel(input pattern_t pat, input int idx);
      logic [7:0]  x;
      logic [7:0]  y;
      logic [15:0] px;
      x = 8'(idx % `FRAME_WIDTH);
      y = 8'(idx / `FRAME_WIDTH);
      case (pat)
         2'd0:    px = {y, x};
         2'd1:    px = 16'hf800;
         2'd2:    px = (x[0] != y[0]) ? 16'hffff : 16'h0000;
         default: px = {x[4:0], y[5:0], ~x[4:0]};
      endcase
      return px;
   endfunction

   // First pixel of the word lands in the top 16 bits
   function automatic logic [63:0] build_word(input pattern_t pat, input int w,
                                              input int bad_idx);
      logic [63:0] word;
      logic [15:0] px;
      int          idx;
      word = '0;
      for (int k = 0; k < `PIXELS_PER_WORD; k++) begin
         idx = w * `PIXELS_PER_WORD + k;
         px  = expected_pixel(pat, idx);
         if (idx == bad_idx) begin
            px = px ^ 16'h8421;
         end
         word = {word[47:0], px};
      end
      return word;
   endfunction

   // ****************************************
   // Checks and drivers
   // ****************************************

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      assert (got === exp) else begin
         $display("Fail at %0d ns: %s is %b, expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_int(input string name, input int got, input int exp);
      checks++;
      assert (got == exp) else begin
         $display("Fail at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
         errors++;
      end
   endtask

   // Long enough for the synchronizer and edge detector
   task automatic press_button();
      @(negedge rx_vga_clk);
      pattern_btn = 1'b1;
      repeat (4) @(negedge rx_vga_clk);
      pattern_btn = 1'b0;
      repeat (4) @(negedge rx_vga_clk);
   endtask

   // Words WORD_GAP cycles apart, then a vsync rising edge
   task automatic send_frame(input pattern_t pat, input int bad_idx);
      for (int w = 0; w < WORDS_PER_FRAME; w++) begin
         @(negedge rx_vga_clk);
         rx_valid = 1'b1;
         rx_data  = build_word(pat, w, bad_idx);
         @(negedge rx_vga_clk);
         rx_valid = 1'b0;
         repeat (WORD_GAP - 2) @(negedge rx_vga_clk);
      end
      @(negedge rx_vga_clk);
      rx_vsync = 1'b1;
      // Frame start edge, then the registered pass flag
      repeat (2) @(negedge rx_vga_clk);
      rx_vsync = 1'b0;
   endtask

   task automatic count_clear_pulses(output int pulses, output int gap);
      int first_at;
      int last_at;
      pulses   = 0;
      first_at = -1;
      last_at  = -1;
      for (int c = 0; c < 2 * `ERR_CHECK_PERIOD; c++) begin
         @(negedge rx_vga_clk);
         if (rx_clear) begin
            pulses++;
            if (first_at < 0) begin
               first_at = c;
            end
            last_at = c;
         end
      end
      gap = last_at - first_at;
   endtask

   task automatic run_row(input int idx);
      row_t     row;
      pattern_t send_pat;
      int       bad_idx;
      int       pulses;
      int       gap;
      int       errors_before;
      row           = TEST_ROWS[idx];
      errors_before = errors;
      repeat (row.presses) begin
         press_button();
         model_pat = model_pat + 2'd1;
      end
      @(negedge rx_vga_clk);
      rx_error = row.status;
      // Status register, then pass register
      repeat (2) @(negedge rx_vga_clk);
      if (row.status != CLEAN) begin
         check_bit("frame_pass_o", frame_pass, 1'b0);
      end
      count_clear_pulses(pulses, gap);
      if (row.status != CLEAN) begin
         check_int("rx_clear_o pulse count", pulses, 2);
         check_int("rx_clear_o pulse spacing", gap, `ERR_CHECK_PERIOD);
      end else begin
         check_int("rx_clear_o pulse count", pulses, 0);
      end
      send_pat = row.wrong_pat ? model_pat + 2'd1 : model_pat;
      bad_idx  = -1;
      if (row.corrupt) begin
         rng_state = xorshift32(rng_state);
         bad_idx   = int'(rng_state % 32'(`FRAME_PIXELS));
      end
      // Only the second frame decides the result
      send_frame(send_pat, -1);
      send_frame(send_pat, bad_idx);
      check_bit("frame_pass_o", frame_pass, row.exp_pass);
      if (row.exp_pass) begin
         // Flash counter top bit stays low over the short run
         check_bit("led_a_o", led_a, 1'b0);
         check_bit("led_b_o", led_b, 1'b1);
      end else begin
         check_bit("led_a_o", led_a, 1'b1);
         check_bit("led_b_o", led_b, 1'b1);
      end
      $display("test %0d: pattern %0d, status %h, bad pixel %0d, %0d errors",
               idx, send_pat, row.status, bad_idx, errors - errors_before);
   endtask

   // ****************************************
   // Main sequence and watchdog
   // ****************************************

   initial begin
      rx_valid    = 1'b0;
      rx_data     = '0;
      rx_vsync    = 1'b0;
      rx_error    = CLEAN;
      pattern_btn = 1'b0;
      model_pat   = '0;
      rng_state   = 32'ha95277d9;
      checks      = 0;
      errors      = 0;
      wait (rst_n === 1'b1);
      check_bit("frame_pass_o", frame_pass, 1'b0);
      check_bit("led_a_o", led_a, 1'b1);
      check_bit("led_b_o", led_b, 1'b1);
      check_bit("rx_clear_o", rx_clear, 1'b1);
      $display("reset values: %0d errors", errors);
      for (int i = 0; i < NUM_ROWS; i++) begin
         run_row(i);
      end
      $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
               NUM_ROWS + 1, checks, errors, dut.u_asserts.fail_cnt);
      if (errors == 0 && dut.u_asserts.fail_cnt == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("TEST FAILED");
      $finish;
   end

endmodule

/* list.f */
+incdir+hw
hw/video_pkg.sv
hw/mipi_rx_pkg.sv
hw/pattern_select.sv
hw/golden_pattern.sv
hw/pixel_depacker.sv
hw/error_monitor.sv
hw/frame_checker.sv
hw/loopback_checker_top.sv
tb/tb_clock_gen.sv
tb/loopback_checker_asserts.sv
tb/loopback_checker_tb.sv

/* Makefile */
# Verilator build and run of the loopback checker testbench

BIN  := obj_dir/Vloopback_checker_tb
SRCS := $(shell grep -v '^+' list.f) hw/loopback_params.svh

.PHONY: run clean

run: $(BIN)
	./$(BIN) +verilator+error+limit+100 | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

# Rebuilt only when a source or the file list changes
$(BIN): list.f $(SRCS)
	verilator --binary --timing --assert -f list.f --top-module loopback_checker_tb -Mdir obj_dir

clean:
	rm -rf obj_dir sim.log
